//--- src/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

	// ***********************************************************
	// Cache organisation
	// ***********************************************************
	localparam int LINES         = 64; // Sets per way
	localparam int LINESIZE      = 8;  // Words per line
	localparam int ASSOCIATIVITY = 2;
	localparam int CACHEBURST    = 4;  // Words per CPU fetch

	localparam int WORD_ADDR_BITS = 30;

	// ***********************************************************
	// Derived widths
	// ***********************************************************
	localparam int OFFSET_BITS   = $clog2(LINESIZE);
	localparam int INDEX_BITS    = $clog2(LINES);
	localparam int WAY_BITS      = $clog2(ASSOCIATIVITY);
	localparam int BURST_BITS    = $clog2(CACHEBURST);
	localparam int RAM_ADDR_BITS = INDEX_BITS + OFFSET_BITS;
	localparam int TAG_BITS      = WORD_ADDR_BITS - RAM_ADDR_BITS;

	// Snooped writes only reach the low 256 MB of the address space
	localparam int SNOOP_ADDR_BITS  = 26;
	localparam int SNOOP_DEPTH_BITS = 4;

endpackage

`default_nettype wire

//--- src/icache_bus_pkg.sv
`default_nettype none

package icache_bus_pkg;

	import icache_geom_pkg::*;

	// A data write seen on the other master's bus
	typedef struct packed {
		logic [3:0]                 be;
		logic [31:0]                data;
		logic [SNOOP_ADDR_BITS-1:0] addr; // Word address
	} snoop_write_t;

	// One write into the data memory of the ways, en selects the ways
	typedef struct packed {
		logic [RAM_ADDR_BITS-1:0] addr;
		logic [31:0]              data;
		logic [3:0]               be;
		logic [ASSOCIATIVITY-1:0] en;
	} way_write_t;

endpackage

`default_nettype wire

//--- src/snoop_queue.sv
`default_nettype none

module snoop_queue import icache_geom_pkg::*, icache_bus_pkg::*; (
	input  logic         CLK,
	input  logic         RESET,

	input  logic         push,
	input  snoop_write_t din,

	input  logic         pop,
	output snoop_write_t dout,
	output logic         empty
);

	snoop_write_t buffer [1 << SNOOP_DEPTH_BITS];

	logic [SNOOP_DEPTH_BITS-1:0] wr_ptr;
	logic [SNOOP_DEPTH_BITS-1:0] rd_ptr;
	logic [SNOOP_DEPTH_BITS:0]   count;
	logic                        full;

	assign empty = (count == '0);
	assign full  = count[SNOOP_DEPTH_BITS]; // Only set at exactly 16 entries
	assign dout  = buffer[rd_ptr];

	always_ff @(posedge CLK) begin
		if (push)
			buffer[wr_ptr] <= din;
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Pointers wrap on their own
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// The snooping master is expected to throttle itself
	a_no_overflow: assert property (@(posedge CLK) disable iff (RESET) !(push && full))
		else $error("snoop queue overflow");

	a_no_underflow: assert property (@(posedge CLK) disable iff (RESET) !(pop && empty))
		else $error("snoop queue popped while empty");

endmodule

`default_nettype wire

//--- src/icache_way.sv
`default_nettype none

module icache_way import icache_geom_pkg::*, icache_bus_pkg::*; (
	input  logic                      CLK,
	input  logic                      RESET,

	input  logic [WORD_ADDR_BITS-1:0] lookup_addr,
	input  logic [RAM_ADDR_BITS-1:0]  rd_addr,
	input  way_write_t                wr,
	input  logic                      tag_we,
	input  logic [WAY_BITS-1:0]       way_index,

	output logic                      hit,
	output logic [31:0]               rdata
);

	logic [TAG_BITS-1:0]      tag_mem [LINES];
	logic [LINES-1:0]         valid;
	logic [31:0]              data_mem [LINES * LINESIZE];
	logic [RAM_ADDR_BITS-1:0] rd_addr_q;

	logic [INDEX_BITS-1:0]    index;
	logic [TAG_BITS-1:0]      tag;
	logic                     we;

	assign index = lookup_addr[RAM_ADDR_BITS-1:OFFSET_BITS];
	assign tag   = lookup_addr[WORD_ADDR_BITS-1:RAM_ADDR_BITS];
	assign hit   = valid[index] && (tag_mem[index] == tag);
	assign we    = wr.en[way_index];

	// ***********************************************************
	// Tag side
	// ***********************************************************
	always_ff @(posedge CLK) begin
		if (RESET)
			valid <= '0;
		else if (tag_we)
			valid[index] <= 1'b1; // A tag write always completes a line fill
	end

	always_ff @(posedge CLK) begin
		if (tag_we)
			tag_mem[index] <= tag;
	end

	// ***********************************************************
	// Data side
	// ***********************************************************
	always_ff @(posedge CLK) begin
		rd_addr_q <= rd_addr;
		for (int b = 0; b < 4; b++) begin
			if (we && wr.be[b])
				data_mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
		end
	end

	assign rdata = data_mem[rd_addr_q]; // Word appears one cycle after its address

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`default_nettype none

module icache_ctrl import icache_geom_pkg::*, icache_bus_pkg::*; (
	input  logic                      CLK,
	input  logic                      RESET,

	input  logic                      cpu_req,
	input  logic [31:0]               cpu_addr,
	output logic                      cpu_valid,
	output logic                      cpu_done,

	output logic                      mem_req,
	output logic [31:0]               mem_addr,
	input  logic                      mem_done,
	input  logic [31:0]               mem_data,

	input  snoop_write_t              snoop_head,
	input  logic                      snoop_empty,
	output logic                      snoop_pop,

	output logic [WORD_ADDR_BITS-1:0] lookup_addr,
	output logic [RAM_ADDR_BITS-1:0]  rd_addr,
	output way_write_t                wr,
	output logic [ASSOCIATIVITY-1:0]  tag_we,
	input  logic [ASSOCIATIVITY-1:0]  hits,
	output logic [WAY_BITS-1:0]       way_sel
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SNOOP,
		S_LOOKUP,
		S_FILL,
		S_COMMIT
	} state_t;

	state_t state;

	logic [WORD_ADDR_BITS-1:0] addr_q;    // Word being looked up or snooped
	logic [WORD_ADDR_BITS-1:0] hold_addr;
	logic                      req_hold;
	logic [31:0]               snoop_data;
	logic [3:0]                snoop_be;

	logic [BURST_BITS-1:0]     burst_cnt;
	logic [OFFSET_BITS-1:0]    fill_cnt;
	logic [WAY_BITS-1:0]       victim;
	logic [WAY_BITS-1:0]       rr [LINES]; // Next victim of each set

	logic [INDEX_BITS-1:0]     index;
	logic [WAY_BITS-1:0]       hit_way;
	logic [ASSOCIATIVITY-1:0]  victim_oh;

	assign index       = addr_q[RAM_ADDR_BITS-1:OFFSET_BITS];
	assign lookup_addr = addr_q;
	assign rd_addr     = addr_q[RAM_ADDR_BITS-1:0];
	assign victim_oh   = ASSOCIATIVITY'(1) << victim;
	assign snoop_pop   = (state == S_IDLE) && !snoop_empty;
	assign tag_we      = (state == S_COMMIT) ? victim_oh : '0;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < ASSOCIATIVITY; w++) begin
			if (hits[w])
				hit_way = WAY_BITS'(w);
		end
	end

	// ***********************************************************
	// Data memory write port
	// ***********************************************************
	always_comb begin
		wr.addr = addr_q[RAM_ADDR_BITS-1:0];
		wr.data = snoop_data;
		wr.be   = snoop_be;
		wr.en   = '0;
		case (state)
			S_SNOOP: wr.en = hits; // Only a way that already holds the word
			S_FILL: begin
				wr.addr = {index, fill_cnt};
				wr.data = mem_data;
				wr.be   = 4'hF;
				if (mem_done)
					wr.en = victim_oh;
			end
			default: wr.en = '0;
		endcase
	end

	// ***********************************************************
	// Main FSM
	// ***********************************************************
	always_ff @(posedge CLK) begin
		cpu_valid <= 1'b0;
		cpu_done  <= 1'b0;
		if (cpu_req)
			hold_addr <= cpu_addr[31:2];

		if (RESET) begin
			state    <= S_IDLE;
			req_hold <= 1'b0;
			mem_req  <= 1'b0;
			for (int i = 0; i < LINES; i++)
				rr[i] <= '0;
		end else begin
			if (cpu_req)
				req_hold <= 1'b1; // Served once the FSM is back in idle

			case (state)
				S_IDLE: begin
					if (!snoop_empty) begin
						state      <= S_SNOOP;
						addr_q     <= WORD_ADDR_BITS'(snoop_head.addr);
						snoop_data <= snoop_head.data;
						snoop_be   <= snoop_head.be;
					end else if (cpu_req || req_hold) begin
						state     <= S_LOOKUP;
						addr_q    <= cpu_req ? cpu_addr[31:2] : hold_addr;
						req_hold  <= 1'b0;
						burst_cnt <= '0;
					end
				end

				S_SNOOP: state <= S_IDLE;

				S_LOOKUP: begin
					if (|hits) begin
						cpu_valid <= 1'b1;
						way_sel   <= hit_way;
						addr_q    <= addr_q + 1'b1;
						if (burst_cnt == BURST_BITS'(CACHEBURST - 1)) begin
							cpu_done <= 1'b1;
							state    <= S_IDLE;
						end else begin
							burst_cnt <= burst_cnt + 1'b1;
						end
					end else begin
						mem_req  <= 1'b1;
						mem_addr <= {addr_q[WORD_ADDR_BITS-1:OFFSET_BITS],
							{OFFSET_BITS{1'b0}}, 2'b00};
						fill_cnt <= '0;
						victim   <= rr[index];
						state    <= S_FILL;
					end
				end

				S_FILL: begin
					if (mem_done) begin
						mem_req  <= 1'b0;
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_cnt == OFFSET_BITS'(LINESIZE - 1))
							state <= S_COMMIT;
					end
				end

				// Ways write the tag and valid bit in this cycle
				S_COMMIT: begin
					rr[index] <= rr[index] + 1'b1;
					state     <= S_LOOKUP; // Same word again, now a hit
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	// A line is only ever allocated after it missed in every way
	a_single_hit: assert property (@(posedge CLK) disable iff (RESET) $onehot0(hits))
		else $error("more than one way hits");

	a_single_write: assert property (@(posedge CLK) disable iff (RESET) $onehot0(wr.en))
		else $error("data written to more than one way");

endmodule

`default_nettype wire

//--- src/icache_top.sv
`default_nettype none

module icache_top import icache_geom_pkg::*, icache_bus_pkg::*; (
	input  logic         CLK,
	input  logic         RESET,

	input  logic         cpu_req,
	input  logic [31:0]  cpu_addr,
	output logic         cpu_valid,
	output logic         cpu_done,
	output logic [31:0]  cpu_data,

	output logic         mem_req,
	output logic [31:0]  mem_addr,
	input  logic         mem_done,
	input  logic [31:0]  mem_data,

	input  logic         snoop_we,
	input  snoop_write_t snoop
);

	snoop_write_t              snoop_head;
	logic                      snoop_empty;
	logic                      snoop_pop;

	logic [WORD_ADDR_BITS-1:0] lookup_addr;
	logic [RAM_ADDR_BITS-1:0]  rd_addr;
	way_write_t                wr;
	logic [ASSOCIATIVITY-1:0]  tag_we;
	logic [ASSOCIATIVITY-1:0]  hits;
	logic [WAY_BITS-1:0]       way_sel;
	logic [31:0]               way_rdata [ASSOCIATIVITY];

	snoop_queue u_queue (
		.CLK   (CLK),
		.RESET (RESET),
		.push  (snoop_we),
		.din   (snoop),
		.pop   (snoop_pop),
		.dout  (snoop_head),
		.empty (snoop_empty)
	);

	icache_ctrl u_ctrl (
		.CLK         (CLK),
		.RESET       (RESET),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.cpu_valid   (cpu_valid),
		.cpu_done    (cpu_done),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_done    (mem_done),
		.mem_data    (mem_data),
		.snoop_head  (snoop_head),
		.snoop_empty (snoop_empty),
		.snoop_pop   (snoop_pop),
		.lookup_addr (lookup_addr),
		.rd_addr     (rd_addr),
		.wr          (wr),
		.tag_we      (tag_we),
		.hits        (hits),
		.way_sel     (way_sel)
	);

	for (genvar i = 0; i < ASSOCIATIVITY; i++) begin : g_way
		icache_way u_way (
			.CLK         (CLK),
			.RESET       (RESET),
			.lookup_addr (lookup_addr),
			.rd_addr     (rd_addr),
			.wr          (wr),
			.tag_we      (tag_we[i]),
			.way_index   (WAY_BITS'(i)),
			.hit         (hits[i]),
			.rdata       (way_rdata[i])
		);
	end

	assign cpu_data = way_rdata[way_sel]; // Way that hit on the previous cycle

endmodule

`default_nettype wire

//--- sim/tb_icache.sv
`default_nettype none

module tb_icache import icache_geom_pkg::*, icache_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'h11b6_d0ae;
	localparam int MEM_WORDS     = 4096;
	localparam int COLD_BURSTS   = 8;
	localparam int CROSS_BURSTS  = 8;
	localparam int SNOOP_CASES   = 4;
	localparam int RANDOM_BURSTS = 150;
	localparam int TOTAL_BURSTS  = 2 * COLD_BURSTS + CROSS_BURSTS + 6 + 3 * SNOOP_CASES
		+ RANDOM_BURSTS;
	localparam int CYCLE_LIMIT   = TOTAL_BURSTS * 200 + 1000;

	logic         CLK;
	logic         RESET;
	logic         cpu_req;
	logic [31:0]  cpu_addr;
	logic         cpu_valid;
	logic         cpu_done;
	logic [31:0]  cpu_data;
	logic         mem_req;
	logic [31:0]  mem_addr;
	logic         mem_done;
	logic [31:0]  mem_data;
	logic         snoop_we;
	snoop_write_t snoop;

	logic [31:0]         mem_model [MEM_WORDS];
	logic                model_valid [ASSOCIATIVITY][LINES];
	logic [TAG_BITS-1:0] model_tag [ASSOCIATIVITY][LINES];
	logic [WAY_BITS-1:0] model_rr [LINES];
	logic [31:0]         fills [$];          // mem_addr of every fill the DUT started
	logic [31:0]         expected_fills [$];

	logic [31:0] stim_rng;
	logic [31:0] mem_rng;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_errors = 0;
	int          cycles = 0;

	icache_top DUT (
		.CLK       (CLK),
		.RESET     (RESET),
		.cpu_req   (cpu_req),
		.cpu_addr  (cpu_addr),
		.cpu_valid (cpu_valid),
		.cpu_done  (cpu_done),
		.cpu_data  (cpu_data),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_done  (mem_done),
		.mem_data  (mem_data),
		.snoop_we  (snoop_we),
		.snoop     (snoop)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ************************************************************
	// Helpers
	// ************************************************************
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] stim_rand();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	function automatic logic [31:0] init_word(input int a);
		logic [31:0] x;
		x = 32'(a) * 32'h9e37_79b1;
		return x ^ (x >> 15) ^ 32'h5bd1_e995;
	endfunction

	function automatic logic line_cached(input int wa);
		int                  idx;
		logic [TAG_BITS-1:0] t;
		logic                found;
		idx = (wa / LINESIZE) % LINES;
		t = TAG_BITS'(wa / (LINES * LINESIZE));
		found = 1'b0;
		for (int k = 0; k < ASSOCIATIVITY; k++) begin
			if (model_valid[k][idx] && model_tag[k][idx] == t)
				found = 1'b1;
		end
		return found;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	// Walks the burst through the tag model and lists the lines it must fill
	task automatic predict_burst(input int w);
		int                  wa;
		int                  idx;
		logic [WAY_BITS-1:0] way;
		expected_fills.delete();
		for (int i = 0; i < CACHEBURST; i++) begin
			wa = w + i;
			if (!line_cached(wa)) begin
				idx = (wa / LINESIZE) % LINES;
				way = model_rr[idx];
				model_valid[way][idx] = 1'b1;
				model_tag[way][idx] = TAG_BITS'(wa / (LINES * LINESIZE));
				model_rr[idx] = model_rr[idx] + 1'b1;
				expected_fills.push_back(32'((wa / LINESIZE) * LINESIZE * 4));
			end
		end
	endtask

	task automatic drive_snoop(input int sw, input logic [31:0] data, input logic [3:0] be);
		snoop.addr = SNOOP_ADDR_BITS'(sw);
		snoop.data = data;
		snoop.be   = be;
		snoop_we   = 1'b1;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				mem_model[sw][8*b +: 8] = data[8*b +: 8]; // Memory sees the write at once
		end
	endtask

	task automatic snoop_at(input int sw);
		logic [31:0] r;
		logic [3:0]  be;
		r = stim_rand();
		be = r[3:0];
		if (be == 4'h0)
			be = 4'hF; // Every snoop changes at least one byte
		drive_snoop(sw, stim_rand(), be);
		@(negedge CLK);
		snoop_we = 1'b0;
	endtask

	// One fetch burst; with snoops_on, writes to other lines are snooped meanwhile
	task automatic run_burst(input int w, input logic snoops_on);
		logic [31:0] expect_data [CACHEBURST];
		logic [31:0] r;
		int          got;
		int          lo_line;
		int          hi_line;
		int          sw;
		int          n_snoops;
		for (int i = 0; i < CACHEBURST; i++)
			expect_data[i] = mem_model[w + i];
		predict_burst(w);
		fills.delete();
		lo_line = w / LINESIZE;
		hi_line = (w + CACHEBURST - 1) / LINESIZE;
		got = 0;
		n_snoops = 0;
		cpu_req = 1'b1;
		cpu_addr = 32'(w) << 2;
		while (got < CACHEBURST) begin
			@(negedge CLK);
			cpu_req = 1'b0;
			snoop_we = 1'b0;
			if (cpu_valid) begin
				compare("cpu_data", cpu_data, expect_data[got]);
				compare("cpu_done", 32'(cpu_done), 32'(got == CACHEBURST - 1));
				got++;
			end else begin
				compare("cpu_done", 32'(cpu_done), 32'h0);
			end
			r = stim_rand();
			if (snoops_on && n_snoops < 6 && r[2:0] == 3'd0) begin
				sw = int'(r[31:20]);
				if (sw / LINESIZE != lo_line && sw / LINESIZE != hi_line) begin
					drive_snoop(sw, stim_rand(), r[7:4]);
					n_snoops++;
				end
			end
		end
		@(negedge CLK);
		snoop_we = 1'b0;
		compare("cpu_valid", 32'(cpu_valid), 32'h0); // Nothing beyond the fourth word
		compare("cpu_done", 32'(cpu_done), 32'h0);
		compare("mem_req count", 32'(fills.size()), 32'(expected_fills.size()));
		foreach (expected_fills[i]) begin
			if (i < fills.size())
				compare("mem_addr", fills[i], expected_fills[i]);
		end
	endtask

	// ************************************************************
	// Memory responder
	// ************************************************************
	initial begin : memory_responder
		int base;
		mem_done = 1'b0;
		mem_data = '0;
		mem_rng = xorshift(SEED ^ 32'h0f0f_0f0f);
		forever begin
			@(negedge CLK);
			if (mem_req === 1'b1) begin
				fills.push_back(mem_addr);
				base = int'(mem_addr[13:2]);
				for (int k = 0; k < LINESIZE; k++) begin
					mem_rng = xorshift(mem_rng);
					repeat (mem_rng[1:0]) @(negedge CLK); // Stall between words
					mem_done = 1'b1;
					mem_data = mem_model[(base + k) % MEM_WORDS];
					@(negedge CLK);
					mem_done = 1'b0;
				end
			end
		end
	end

	// ************************************************************
	// Test sequence
	// ************************************************************
	initial begin : main
		int w;
		int s;
		int tag_base;
		int starts [$];
		logic [31:0] r;
		CLK = 1'b0;
		RESET = 1'b1;
		cpu_req = 1'b0;
		cpu_addr = '0;
		snoop_we = 1'b0;
		snoop = '0;
		stim_rng = SEED;
		for (int a = 0; a < MEM_WORDS; a++)
			mem_model[a] = init_word(a);
		for (int i = 0; i < LINES; i++) begin
			model_rr[i] = '0;
			for (int k = 0; k < ASSOCIATIVITY; k++) begin
				model_valid[k][i] = 1'b0;
				model_tag[k][i] = '0;
			end
		end
		repeat (16) @(negedge CLK);
		RESET = 1'b0;

		@(negedge CLK);
		compare("cpu_valid", 32'(cpu_valid), 32'h0);
		compare("cpu_done", 32'(cpu_done), 32'h0);
		compare("mem_req", 32'(mem_req), 32'h0);
		report_test("reset");

		for (int i = 0; i < COLD_BURSTS; i++) begin
			w = int'(stim_rand() % (MEM_WORDS - CACHEBURST));
			starts.push_back(w);
			run_burst(w, 1'b0);
		end
		report_test("cold bursts");

		foreach (starts[i])
			run_burst(starts[i], 1'b0);
		for (int i = 0; i < CROSS_BURSTS; i++) begin
			w = int'(stim_rand() % 500) * LINESIZE + 5 + int'(stim_rand() % 3); // Ends in next line
			run_burst(w, 1'b0);
		end
		report_test("repeat and line crossing");

		s = int'(stim_rand() % LINES);
		tag_base = int'(stim_rand() % 6);
		for (int round = 0; round < 2; round++) begin
			for (int t = 0; t < 3; t++)
				run_burst(((tag_base + t) * LINES + s) * LINESIZE, 1'b0);
		end
		report_test("round robin eviction");

		for (int i = 0; i < SNOOP_CASES; i++) begin
			w = int'(stim_rand() % 512) * LINESIZE;
			run_burst(w, 1'b0);
			snoop_at(w + int'(stim_rand() % 4));
			run_burst(w, 1'b0);
			do begin
				w = int'(stim_rand() % 512) * LINESIZE;
			end while (line_cached(w));
			fills.delete();
			snoop_at(w + 1);
			repeat (4) @(negedge CLK);
			compare("mem_req count", 32'(fills.size()), 32'h0);
			run_burst(w, 1'b0);
		end
		report_test("snoops");

		for (int i = 0; i < RANDOM_BURSTS; i++) begin
			r = stim_rand();
			w = r[4] ? int'(r[31:8] % 1020) : int'(r[31:8] % (MEM_WORDS - CACHEBURST));
			repeat (int'(r[1:0]))
				snoop_at(int'(stim_rand() % MEM_WORDS));
			run_burst(w, 1'b1);
		end
		report_test("random mix");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/icache_geom_pkg.sv
src/icache_bus_pkg.sv
src/snoop_queue.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/tb_icache.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_icache -f project.f -o tb_icache \
	&& ./obj_dir/tb_icache > sim.log 2>&1 \
	|| echo "Test FAILED" >> sim.log
cat sim.log
! grep -q "Test FAILED" sim.log
